// File: dcache_rd.f
+incdir+design
design/dcache_cfg_pkg.sv
design/dcache_msg_pkg.sv
design/dcache_arr_if.sv
design/dcache_miss_if.sv
design/dcache_rd_ctrl.sv
design/dcache_mem.sv
design/dcache_miss_unit.sv
design/dcache_rd_top.sv
verif/dcache_rd_tb_mem.sv
verif/dcache_rd_tb.sv

// File: design/dcache_arr_if.sv
`timescale 1ns/1ps

interface dcache_arr_if
  import dcache_cfg_pkg::*;
();

  // read request, index and offset now, tag one cycle later
  logic     rd_req;
  idx_t     rd_idx;
  off_t     rd_off;
  tag_t     rd_tag;
  // array response
  logic     rd_ack;
  word_t    rd_data;
  way_vec_t rd_vld_bits;
  way_vec_t rd_hit_oh;
  // refill write owns the arrays this cycle
  logic     wr_cl_vld;

  modport ctrl (output rd_req, rd_idx, rd_off, rd_tag,
                input  rd_ack, rd_data, rd_vld_bits, rd_hit_oh, wr_cl_vld);
  modport mem  (input  rd_req, rd_idx, rd_off, rd_tag,
                output rd_ack, rd_data, rd_vld_bits, rd_hit_oh, wr_cl_vld);

endinterface

// File: design/dcache_cfg_pkg.sv
`include "dcache_defines.svh"

package dcache_cfg_pkg;

  // address layout
  typedef logic [`DC_PLEN-1:0]  paddr_t;
  typedef logic [`DC_TAG_W-1:0] tag_t;
  typedef logic [`DC_IDX_W-1:0] idx_t;
  typedef logic [`DC_OFF_W-1:0] off_t;

  // data widths, one line is all bytes of the offset range
  typedef logic [`DC_WORD_W-1:0]       word_t;
  typedef logic [(8<<`DC_OFF_W)-1:0]   line_t;

  // one bit per way
  // valid bits and one-hot hit vector
  typedef logic [`DC_WAYS-1:0] way_vec_t;

endpackage

// File: design/dcache_defines.svh
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// cache geometry
// 2-way set associative, 16 sets, 16 byte lines

// physical address and data word widths
`define DC_PLEN   32
`define DC_WORD_W 32

// address split, tag | index | offset
`define DC_OFF_W  4
`define DC_IDX_W  4
`define DC_TAG_W  24

// associativity
`define DC_WAYS   2

`endif

// File: design/dcache_mem.sv
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_mem
  import dcache_cfg_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  dcache_arr_if.mem arr,
  // refill from the miss unit
  input  logic     refill_we_i,
  input  idx_t     refill_idx_i,
  input  way_vec_t refill_way_i,
  input  tag_t     refill_tag_i,
  input  line_t    refill_line_i
);

  localparam int unsigned NSETS      = 1 << `DC_IDX_W;
  localparam int unsigned WORD_OFF_W = $clog2(`DC_WORD_W / 8);

  tag_t     tag_mem  [`DC_WAYS][NSETS];
  line_t    data_mem [`DC_WAYS][NSETS];
  way_vec_t vld_mem  [NSETS];

  // registered read port
  tag_t     tag_rd_q  [`DC_WAYS];
  word_t    word_rd_q [`DC_WAYS];
  way_vec_t vld_rd_q;
  way_vec_t hit_oh;
  logic     rd_en;
  logic [`DC_OFF_W-WORD_OFF_W-1:0] wsel;

  // refill has priority over the read
  assign rd_en         = arr.rd_req & ~refill_we_i;
  assign arr.rd_ack    = ~refill_we_i;
  assign arr.wr_cl_vld = refill_we_i;
  assign wsel          = arr.rd_off[`DC_OFF_W-1:WORD_OFF_W];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < NSETS; s++) begin
        vld_mem[s] <= '0;
      end
      vld_rd_q <= '0;
    end else begin
      if (refill_we_i) begin
        vld_mem[refill_idx_i] <= vld_mem[refill_idx_i] | refill_way_i;
      end
      if (rd_en) begin
        vld_rd_q <= vld_mem[arr.rd_idx];
      end
    end
  end

  // tags and data, per way
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < `DC_WAYS; w++) begin
      if (refill_we_i && refill_way_i[w]) begin
        tag_mem[w][refill_idx_i]  <= refill_tag_i;
        data_mem[w][refill_idx_i] <= refill_line_i;
      end
      if (rd_en) begin
        tag_rd_q[w]  <= tag_mem[w][arr.rd_idx];
        word_rd_q[w] <= data_mem[w][arr.rd_idx][wsel*`DC_WORD_W +: `DC_WORD_W];
      end
    end
  end

  // tag compare against the tag of this cycle
  always_comb begin
    arr.rd_data = '0;
    for (int w = 0; w < `DC_WAYS; w++) begin
      hit_oh[w] = vld_rd_q[w] && (tag_rd_q[w] == arr.rd_tag);
      if (hit_oh[w]) begin
        arr.rd_data = arr.rd_data | word_rd_q[w];
      end
    end
  end

  assign arr.rd_hit_oh   = hit_oh;
  assign arr.rd_vld_bits = vld_rd_q;

endmodule

// File: design/dcache_miss_if.sv
`timescale 1ns/1ps

interface dcache_miss_if
  import dcache_cfg_pkg::*;
();

  // miss request, held until ack
  logic     miss_req;
  paddr_t   miss_paddr;
  logic     miss_nc;
  // valid bits of the missed set, for victim choice
  way_vec_t miss_vld_bits;
  // single cycle ack
  logic     miss_ack;
  // one return pulse per acked miss, killed or not
  logic     miss_rtrn_vld;
  word_t    miss_rtrn_word;

  modport ctrl (output miss_req, miss_paddr, miss_nc, miss_vld_bits,
                input  miss_ack, miss_rtrn_vld, miss_rtrn_word);
  modport miss (input  miss_req, miss_paddr, miss_nc, miss_vld_bits,
                output miss_ack, miss_rtrn_vld, miss_rtrn_word);

endinterface

// File: design/dcache_miss_unit.sv
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_miss_unit
  import dcache_cfg_pkg::*;
  import dcache_msg_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  dcache_miss_if.miss miss,
  // refill port of the arrays
  output logic     refill_we_o,
  output idx_t     refill_idx_o,
  output way_vec_t refill_way_o,
  output tag_t     refill_tag_o,
  output line_t    refill_line_o,
  // external memory
  output logic     mem_req_o,
  output paddr_t   mem_addr_o,
  output logic     mem_nc_o,
  input  logic     mem_ack_i,
  input  logic     mem_rvalid_i,
  input  line_t    mem_rdata_i
);

  localparam int unsigned WORD_OFF_W = $clog2(`DC_WORD_W / 8);

  typedef enum logic [1:0] {
    MU_IDLE,
    MU_MEM_REQ,
    MU_MEM_WAIT
  } mu_state_e;
  mu_state_e state_d, state_q;

  paddr_t     paddr_q;
  miss_size_t size_q;
  way_vec_t   way_q;
  way_vec_t   victim;
  line_t      line_q;
  logic       rtrn_q;
  logic [(1<<`DC_IDX_W)-1:0]       rr_q;
  logic [`DC_OFF_W-WORD_OFF_W-1:0] wsel;
  idx_t       miss_idx;

  assign miss_idx = miss.miss_paddr[`DC_OFF_W +: `DC_IDX_W];
  assign wsel     = paddr_q[`DC_OFF_W-1:WORD_OFF_W];

  // first invalid way wins, else the round-robin bit
  always_comb begin
    victim = way_vec_t'(1) << rr_q[miss_idx];
    for (int w = `DC_WAYS - 1; w >= 0; w--) begin
      if (!miss.miss_vld_bits[w]) begin
        victim = way_vec_t'(1) << w;
      end
    end
  end

  //////////////////////////////
  // request sequencer
  //////////////////////////////

  always_comb begin
    state_d       = state_q;
    miss.miss_ack = 1'b0;
    mem_req_o     = 1'b0;
    unique case (state_q)
      // ack in the first cycle of miss_req
      MU_IDLE: begin
        if (miss.miss_req) begin
          miss.miss_ack = 1'b1;
          state_d       = MU_MEM_REQ;
        end
      end
      MU_MEM_REQ: begin
        mem_req_o = 1'b1;
        if (mem_ack_i) begin
          state_d = MU_MEM_WAIT;
        end
      end
      MU_MEM_WAIT: begin
        if (mem_rvalid_i) begin
          state_d = MU_IDLE;
        end
      end
      default: begin
        state_d = MU_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= MU_IDLE;
      rtrn_q  <= 1'b0;
      size_q  <= MISS_LINE;
      rr_q    <= '0;
    end else begin
      state_q <= state_d;
      // return one cycle after the memory data
      rtrn_q  <= (state_q == MU_MEM_WAIT) && mem_rvalid_i;
      if (miss.miss_ack) begin
        size_q <= miss.miss_nc ? MISS_WORD : MISS_LINE;
        // full set replaced by round-robin, flip its bit
        if (!miss.miss_nc && (&miss.miss_vld_bits)) begin
          rr_q[miss_idx] <= ~rr_q[miss_idx];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (miss.miss_ack) begin
      paddr_q <= miss.miss_paddr;
      way_q   <= victim;
    end
    if (mem_rvalid_i) begin
      line_q <= mem_rdata_i;
    end
  end

  // line aligned for a refill, word aligned for I/O
  assign mem_addr_o = (size_q == MISS_LINE) ?
                      {paddr_q[`DC_PLEN-1:`DC_OFF_W], {`DC_OFF_W{1'b0}}} :
                      {paddr_q[`DC_PLEN-1:WORD_OFF_W], {WORD_OFF_W{1'b0}}};
  assign mem_nc_o   = (size_q == MISS_WORD);

  // no allocation for single words
  assign refill_we_o   = rtrn_q && (size_q == MISS_LINE);
  assign refill_idx_o  = paddr_q[`DC_OFF_W +: `DC_IDX_W];
  assign refill_tag_o  = paddr_q[`DC_PLEN-1 -: `DC_TAG_W];
  assign refill_way_o  = way_q;
  assign refill_line_o = line_q;

  assign miss.miss_rtrn_vld  = rtrn_q;
  // I/O word sits in the low bits
  assign miss.miss_rtrn_word = (size_q == MISS_WORD) ? line_q[`DC_WORD_W-1:0] :
                               line_q[wsel*`DC_WORD_W +: `DC_WORD_W];

endmodule

// File: design/dcache_msg_pkg.sv
package dcache_msg_pkg;

  // read controller states
  typedef enum logic [2:0] {
    IDLE,
    READ,
    MISS_REQ,
    MISS_WAIT,
    KILL_MISS,
    KILL_MISS_ACK,
    REPLAY_REQ,
    REPLAY_READ
  } rd_state_e;

  // size of a miss transaction
  // single word for I/O or disabled cache, full line otherwise
  typedef enum logic {
    MISS_WORD,
    MISS_LINE
  } miss_size_t;

endpackage

// File: design/dcache_rd_ctrl.sv
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_rd_ctrl
  import dcache_cfg_pkg::*;
  import dcache_msg_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          cache_en_i,
  output logic                          busy_o,
  // core side
  input  logic                          req_i,
  input  logic [`DC_IDX_W+`DC_OFF_W-1:0] index_i,
  input  tag_t                          tag_i,
  input  logic                          tag_valid_i,
  input  logic                          kill_i,
  output logic                          gnt_o,
  output logic                          rvalid_o,
  output word_t                         rdata_o,
  // arrays and miss unit
  dcache_arr_if.ctrl                    arr,
  dcache_miss_if.ctrl                   miss
);

  rd_state_e state_d, state_q;

  tag_t     tag_d, tag_q;
  idx_t     idx_d, idx_q;
  off_t     off_d, off_q;
  way_vec_t vld_d, vld_q;
  logic     save_tag;
  logic     rd_req;
  logic     rd_req_q;
  logic     rd_ack_q;
  logic     acc_nc;

  //////////////////////////////
  // address capture
  //////////////////////////////

  // index and offset on grant, tag with tag_valid
  assign idx_d = gnt_o ? index_i[`DC_IDX_W+`DC_OFF_W-1:`DC_OFF_W] : idx_q;
  assign off_d = gnt_o ? index_i[`DC_OFF_W-1:0] : off_q;
  assign tag_d = save_tag ? tag_i : tag_q;
  // way valid bits of the last read
  assign vld_d = rd_req_q ? arr.rd_vld_bits : vld_q;

  assign arr.rd_req = rd_req;
  assign arr.rd_idx = idx_d;
  assign arr.rd_off = off_d;
  assign arr.rd_tag = tag_d;

  // I/O space is bit 31, the tag msb
  assign acc_nc = ~cache_en_i | tag_d[`DC_TAG_W-1];

  assign miss.miss_paddr    = {tag_q, idx_q, off_q};
  assign miss.miss_nc       = ~cache_en_i | tag_q[`DC_TAG_W-1];
  assign miss.miss_vld_bits = vld_q;

  assign busy_o  = (state_q != IDLE);
  // word from the miss unit at the end of a miss, else array word
  assign rdata_o = (state_q == MISS_WAIT) ? miss.miss_rtrn_word : arr.rd_data;

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_comb begin
    state_d       = state_q;
    save_tag      = 1'b0;
    rd_req        = 1'b0;
    miss.miss_req = 1'b0;
    rvalid_o      = 1'b0;
    gnt_o         = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (req_i) begin
          rd_req = 1'b1;
          if (arr.rd_ack) begin
            gnt_o   = 1'b1;
            state_d = READ;
          end
        end
      end
      // hit check, non-cacheable goes the miss way
      READ, REPLAY_READ: begin
        rd_req = 1'b1;
        if (kill_i) begin
          rvalid_o = 1'b1;
          state_d  = IDLE;
        end else if (tag_valid_i || state_q == REPLAY_READ) begin
          save_tag = (state_q != REPLAY_READ);
          // refill stole the array in or before this read
          if (arr.wr_cl_vld || !rd_ack_q) begin
            state_d = REPLAY_REQ;
          end else if ((|arr.rd_hit_oh) && !acc_nc) begin
            rvalid_o = 1'b1;
            state_d  = IDLE;
            // back to back grant
            if (req_i && arr.rd_ack) begin
              gnt_o   = 1'b1;
              state_d = READ;
            end
          end else begin
            state_d = MISS_REQ;
          end
        end
      end
      MISS_REQ: begin
        miss.miss_req = 1'b1;
        if (kill_i) begin
          rvalid_o = 1'b1;
          state_d  = miss.miss_ack ? KILL_MISS : KILL_MISS_ACK;
        end else if (miss.miss_ack) begin
          state_d = MISS_WAIT;
        end
      end
      MISS_WAIT: begin
        if (kill_i) begin
          rvalid_o = 1'b1;
          state_d  = miss.miss_rtrn_vld ? IDLE : KILL_MISS;
        end else if (miss.miss_rtrn_vld) begin
          rvalid_o = 1'b1;
          state_d  = IDLE;
        end
      end
      REPLAY_REQ: begin
        rd_req = 1'b1;
        if (kill_i) begin
          rvalid_o = 1'b1;
          state_d  = IDLE;
        end else if (arr.rd_ack) begin
          state_d = REPLAY_READ;
        end
      end
      // killed before ack, request still held
      KILL_MISS_ACK: begin
        miss.miss_req = 1'b1;
        if (miss.miss_ack) begin
          state_d = KILL_MISS;
        end
      end
      // wait out the memory transaction
      KILL_MISS: begin
        if (miss.miss_rtrn_vld) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  //////////////////////////////
  // registers
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      rd_req_q <= 1'b0;
      rd_ack_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      rd_req_q <= rd_req;
      rd_ack_q <= arr.rd_ack;
    end
  end

  // address and valid bits
  always_ff @(posedge clk_i) begin
    tag_q <= tag_d;
    idx_q <= idx_d;
    off_q <= off_d;
    vld_q <= vld_d;
  end

endmodule

// File: design/dcache_rd_top.sv
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_rd_top
  import dcache_cfg_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          cache_en_i,
  output logic                          busy_o,
  // core load port
  input  logic                          req_i,
  input  logic [`DC_IDX_W+`DC_OFF_W-1:0] index_i,
  input  tag_t                          tag_i,
  input  logic                          tag_valid_i,
  input  logic                          kill_i,
  output logic                          gnt_o,
  output logic                          rvalid_o,
  output word_t                         rdata_o,
  // external memory
  output logic                          mem_req_o,
  output paddr_t                        mem_addr_o,
  output logic                          mem_nc_o,
  input  logic                          mem_ack_i,
  input  logic                          mem_rvalid_i,
  input  line_t                         mem_rdata_i
);

  dcache_arr_if  arr_if ();
  dcache_miss_if miss_if ();

  // refill path, miss unit back into the arrays
  logic     refill_we;
  idx_t     refill_idx;
  way_vec_t refill_way;
  tag_t     refill_tag;
  line_t    refill_line;

  dcache_rd_ctrl i_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cache_en_i  (cache_en_i),
    .busy_o      (busy_o),
    .req_i       (req_i),
    .index_i     (index_i),
    .tag_i       (tag_i),
    .tag_valid_i (tag_valid_i),
    .kill_i      (kill_i),
    .gnt_o       (gnt_o),
    .rvalid_o    (rvalid_o),
    .rdata_o     (rdata_o),
    .arr         (arr_if.ctrl),
    .miss        (miss_if.ctrl)
  );

  dcache_mem i_mem (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .arr           (arr_if.mem),
    .refill_we_i   (refill_we),
    .refill_idx_i  (refill_idx),
    .refill_way_i  (refill_way),
    .refill_tag_i  (refill_tag),
    .refill_line_i (refill_line)
  );

  dcache_miss_unit i_miss (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .miss          (miss_if.miss),
    .refill_we_o   (refill_we),
    .refill_idx_o  (refill_idx),
    .refill_way_o  (refill_way),
    .refill_tag_o  (refill_tag),
    .refill_line_o (refill_line),
    .mem_req_o     (mem_req_o),
    .mem_addr_o    (mem_addr_o),
    .mem_nc_o      (mem_nc_o),
    .mem_ack_i     (mem_ack_i),
    .mem_rvalid_i  (mem_rvalid_i),
    .mem_rdata_i   (mem_rdata_i)
  );

endmodule

// File: verif/dcache_rd_tb.sv
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_rd_tb
  import dcache_cfg_pkg::*;
();

  localparam word_t DATA_KEY = 32'h5a3c_96e1;

  logic clk_i, rst_ni, cache_en_i, busy_o, req_i, tag_valid_i, kill_i;
  logic gnt_o, rvalid_o, mem_req_o, mem_nc_o, mem_ack_i, mem_rvalid_i;
  logic [`DC_IDX_W+`DC_OFF_W-1:0] index_i;
  tag_t   tag_i;
  word_t  rdata_o;
  paddr_t mem_addr_o;
  line_t  mem_rdata_i;
  logic [2:0]  mem_lat;
  logic [15:0] lfsr_q;
  logic   exp_nc, mem_pending, rd_open;
  paddr_t exp_addr;
  int     errors, checks, tests, fetch_cnt, err0;
  // reference cache of two ways per set
  tag_t   ref_tag [2][16];
  logic   ref_vld [2][16];
  logic   ref_rr  [16];

  dcache_rd_top uut (.*);

  dcache_rd_tb_mem i_tb_mem (
    .clk_i(clk_i), .rst_ni(rst_ni), .lat_i(mem_lat), .mem_req_i(mem_req_o),
    .mem_addr_i(mem_addr_o), .mem_ack_o(mem_ack_i), .mem_rvalid_o(mem_rvalid_i),
    .mem_rdata_o(mem_rdata_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  ////////////////////////////////
  // bus monitors
  ////////////////////////////////

  always @(negedge clk_i) begin
    if (mem_req_o && mem_ack_i) begin
      fetch_cnt++;
    end
  end

  // memory data owed after an ack
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_pending <= 1'b0;
    end else if (mem_ack_i) begin
      mem_pending <= 1'b1;
    end else if (mem_rvalid_i) begin
      mem_pending <= 1'b0;
    end
  end

  // granted load still waiting for its rvalid
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_open <= 1'b0;
    end else if (gnt_o) begin
      rd_open <= 1'b1;
    end else if (rvalid_o) begin
      rd_open <= 1'b0;
    end
  end

  a_nc: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o |-> (mem_nc_o == exp_nc))
    else begin
      errors++;
      $display("** Error at %0t: mem_nc_o = %b, expected %b", $time,
               $sampled(mem_nc_o), $sampled(exp_nc));
    end
  a_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o |-> (mem_addr_o == exp_addr))
    else begin
      errors++;
      $display("** Error at %0t: mem_addr_o = %h, expected %h", $time,
               $sampled(mem_addr_o), $sampled(exp_addr));
    end
  a_busy: assert property (@(posedge clk_i) disable iff (!rst_ni) !busy_o |-> !mem_pending)
    else begin
      errors++;
      $display("busy dropped with memory data outstanding at %0t", $time);
    end
  a_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni) rvalid_o |-> rd_open)
    else begin
      errors++;
      $display("rvalid without an outstanding granted load at %0t", $time);
    end

  ////////////////////////////////
  // helpers
  ////////////////////////////////

  // galois lfsr stepped once per bit taken
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic int unsigned rand_bits(input int n);
    int unsigned v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | lfsr_q[0];
      lfsr_q = lfsr_next(lfsr_q);
    end
    return v;
  endfunction

  function automatic word_t exp_word(input paddr_t a);
    return word_t'(a >> 2) ^ DATA_KEY;
  endfunction

  function automatic logic model_hit(input tag_t t, input idx_t i);
    return (ref_vld[0][i] && ref_tag[0][i] == t) || (ref_vld[1][i] && ref_tag[1][i] == t);
  endfunction

  // first invalid way or else round robin
  task automatic model_fill(input tag_t t, input idx_t i);
    int w;
    if (!ref_vld[0][i]) w = 0;
    else if (!ref_vld[1][i]) w = 1;
    else begin
      w = ref_rr[i];
      ref_rr[i] = ~ref_rr[i];
    end
    ref_vld[w][i] = 1'b1;
    ref_tag[w][i] = t;
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic note_fail(input string what);
    errors++;
    $display("%s at %0t", what, $time);
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s: %s", tests, name, (errors == err0) ? "ok" : "errors");
    err0 = errors;
  endtask

  // one load with an optional kill
  // kill_at of -1 means no kill
  // 0 kills in READ and 1 in MISS_REQ
  // 2 and above kill in MISS_WAIT
  task automatic do_read(input tag_t tag, input idx_t idx, input off_t off, input int kill_at);
    paddr_t addr;
    logic   nc;
    logic   hit;
    int     fetch0;
    int     extra;
    int     t;
    addr    = {tag, idx, off};
    nc      = !cache_en_i || tag[`DC_TAG_W-1];
    hit     = !nc && model_hit(tag, idx);
    fetch0  = fetch_cnt;
    extra   = 0;
    exp_nc  = nc;
    // one word at its own address or the whole line
    exp_addr = nc ? addr : {tag, idx, 4'h0};
    mem_lat = 3'(rand_bits(3) % 6 + 1);
    @(posedge clk_i);
    #2;
    req_i   = 1'b1;
    index_i = {idx, off};
    t = 0;
    do begin
      @(negedge clk_i);
      t++;
    end while (!gnt_o && t < 20);
    if (!gnt_o) note_fail("read request never granted");
    @(posedge clk_i);
    #2;
    req_i = 1'b0;
    if (kill_at == 0) begin
      kill_i = 1'b1;
      @(negedge clk_i);
      check_val("rvalid_o", rvalid_o, 1);
    end else begin
      tag_valid_i = 1'b1;
      tag_i       = tag;
      @(negedge clk_i);
      check_val("rvalid_o", rvalid_o, hit);
      if (hit) check_val("rdata_o", rdata_o, exp_word(addr));
      @(posedge clk_i);
      #2;
      tag_valid_i = 1'b0;
      if (!hit && kill_at > 0) begin
        repeat (kill_at - 1) begin
          @(posedge clk_i);
          #2;
        end
        kill_i = 1'b1;
        @(negedge clk_i);
        check_val("rvalid_o", rvalid_o, 1);
      end else if (!hit) begin
        t = 0;
        do begin
          @(negedge clk_i);
          t++;
        end while (!rvalid_o && t < 60);
        if (!rvalid_o) note_fail("miss never returned rvalid");
        else check_val("rdata_o", rdata_o, exp_word(addr));
      end
    end
    @(posedge clk_i);
    #2;
    kill_i = 1'b0;
    @(negedge clk_i);
    t = 0;
    while (busy_o && t < 60) begin
      if (rvalid_o) extra++;
      @(negedge clk_i);
      t++;
    end
    if (busy_o) note_fail("busy stuck high after a read");
    check_val("extra rvalid", extra, 0);
    check_val("line fetches", fetch_cnt - fetch0, (hit || kill_at == 0) ? 0 : 1);
    if (!hit && !nc && kill_at != 0) model_fill(tag, idx);
  endtask

  ////////////////////////////////
  // tests
  ////////////////////////////////

  initial begin
    tag_t pool [3];
    int   t;
    pool = '{24'h000a11, 24'h000b22, 24'h000c33};
    {cache_en_i, req_i, tag_valid_i, kill_i, index_i, tag_i} = '0;
    {errors, checks, tests, fetch_cnt, err0} = '0;
    lfsr_q = 16'd13;
    mem_lat = 3'd1;
    exp_nc = 1'b0;
    exp_addr = '0;
    foreach (ref_vld[w, s]) ref_vld[w][s] = 1'b0;
    foreach (ref_rr[s]) ref_rr[s] = 1'b0;
    rst_ni = 1'b1;
    #1 rst_ni = 1'b0;
    repeat (4) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    cache_en_i = 1'b1;
    @(negedge clk_i);
    check_val("gnt_o", gnt_o, 0);
    check_val("rvalid_o", rvalid_o, 0);
    check_val("busy_o", busy_o, 0);
    check_val("mem_req_o", mem_req_o, 0);
    do_read(pool[0], 4'd5, 4'h4, -1);
    end_test("first read fetches a line");

    // hit followed by a back to back grant in the hit cycle
    t = fetch_cnt;
    do_read(pool[0], 4'd5, 4'h8, -1);
    @(posedge clk_i);
    #2;
    req_i   = 1'b1;
    index_i = {4'd5, 4'h0};
    @(negedge clk_i);
    @(posedge clk_i);
    #2;
    tag_valid_i = 1'b1;
    tag_i       = pool[0];
    index_i     = {4'd5, 4'hc};
    @(negedge clk_i);
    check_val("rvalid_o", rvalid_o, 1);
    check_val("rdata_o", rdata_o, exp_word({pool[0], 4'd5, 4'h0}));
    check_val("gnt_o", gnt_o, 1);
    @(posedge clk_i);
    #2;
    req_i = 1'b0;
    @(negedge clk_i);
    check_val("rvalid_o", rvalid_o, 1);
    check_val("rdata_o", rdata_o, exp_word({pool[0], 4'd5, 4'hc}));
    @(posedge clk_i);
    #2;
    tag_valid_i = 1'b0;
    check_val("line fetches", fetch_cnt - t, 0);
    end_test("hits and back to back grant");

    // eviction and random reuse on two sets
    do_read(pool[1], 4'd5, 4'h0, -1);
    do_read(pool[2], 4'd5, 4'h0, -1);
    do_read(pool[0], 4'd5, 4'h0, -1);
    for (int i = 0; i < 24; i++) begin
      do_read(pool[rand_bits(2) % 3], rand_bits(1) ? 4'd9 : 4'd5, off_t'(rand_bits(2) << 2), -1);
    end
    end_test("eviction against reference model");

    // uncached word reads
    cache_en_i = 1'b0;
    do_read(24'h000f66, 4'd3, 4'h8, -1);
    cache_en_i = 1'b1;
    do_read(24'h000f66, 4'd3, 4'h8, -1);
    do_read(24'h800d44, 4'd7, 4'h4, -1);
    do_read(24'h800d44, 4'd7, 4'h4, -1);
    end_test("I/O and disabled cache");

    // kills in READ, MISS_REQ and MISS_WAIT
    do_read(24'h001177, 4'd11, 4'h0, 0);
    do_read(24'h001177, 4'd11, 4'h0, -1);
    do_read(24'h002288, 4'd12, 4'h4, 1);
    do_read(24'h002288, 4'd12, 4'h4, -1);
    do_read(24'h003399, 4'd13, 4'h8, 2 + rand_bits(1));
    do_read(24'h003399, 4'd13, 4'hc, -1);
    end_test("kills");

    // next read held on req_i while the refill writes the arrays
    exp_nc = 1'b0;
    exp_addr = {24'h000e55, 4'd2, 4'h0};
    mem_lat = 3'd1;
    @(posedge clk_i);
    #2;
    req_i   = 1'b1;
    index_i = {4'd2, 4'h0};
    @(negedge clk_i);
    @(posedge clk_i);
    #2;
    tag_valid_i = 1'b1;
    tag_i       = 24'h000e55;
    index_i     = {4'd2, 4'h4};
    @(posedge clk_i);
    #2;
    tag_valid_i = 1'b0;
    t = 0;
    do begin
      @(negedge clk_i);
      t++;
    end while (!rvalid_o && t < 60);
    if (!rvalid_o) note_fail("miss never returned rvalid");
    check_val("rdata_o", rdata_o, exp_word({24'h000e55, 4'd2, 4'h0}));
    t = 0;
    do begin
      @(negedge clk_i);
      t++;
    end while (!gnt_o && t < 20);
    if (!gnt_o) note_fail("queued read never granted");
    @(posedge clk_i);
    #2;
    req_i       = 1'b0;
    tag_valid_i = 1'b1;
    @(negedge clk_i);
    check_val("rvalid_o", rvalid_o, 1);
    check_val("rdata_o", rdata_o, exp_word({24'h000e55, 4'd2, 4'h4}));
    @(posedge clk_i);
    #2;
    tag_valid_i = 1'b0;
    end_test("read behind refill");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // whole run watchdog
  initial begin
    #2_000_000;
    $display("run did not finish in time");
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: verif/dcache_rd_tb_mem.sv
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_rd_tb_mem
  import dcache_cfg_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  // cycles from ack to data
  input  logic [2:0] lat_i,
  input  logic       mem_req_i,
  input  paddr_t     mem_addr_i,
  output logic       mem_ack_o,
  output logic       mem_rvalid_o,
  output line_t      mem_rdata_o
);

  // each word is its word address xor this key
  localparam word_t DATA_KEY = 32'h5a3c_96e1;

  logic       busy_q;
  logic [2:0] cnt_q;
  paddr_t     addr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q       <= 1'b0;
      cnt_q        <= '0;
      addr_q       <= '0;
      mem_ack_o    <= 1'b0;
      mem_rvalid_o <= 1'b0;
      mem_rdata_o  <= '0;
    end else begin
      mem_ack_o    <= 1'b0;
      mem_rvalid_o <= 1'b0;
      if (!busy_q) begin
        // single cycle ack then count down the latency
        if (mem_req_i) begin
          mem_ack_o <= 1'b1;
          busy_q    <= 1'b1;
          addr_q    <= mem_addr_i;
          cnt_q     <= lat_i;
        end
      end else if (cnt_q <= 3'd1) begin
        mem_rvalid_o <= 1'b1;
        busy_q       <= 1'b0;
        for (int w = 0; w < 4; w++) begin
          mem_rdata_o[w*32 +: 32] <= word_t'((addr_q >> 2) + w) ^ DATA_KEY;
        end
      end else begin
        cnt_q <= cnt_q - 3'd1;
      end
    end
  end

endmodule
